// ==== sources.f ====
design/cpu_pkg.sv
design/control_block.sv
design/program_counter.sv
design/dff_mem.sv
design/alu.sv
design/datapath.sv
design/tt_um_ece298a_8_bit_cpu_top.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

// ==== bench/cpu_golden.txt ====
# records: P addr data is a program write, R starts a run, E value is an expected OUT
# H means the run must end halted, Q ends the file, all numbers in hex
# run 1: sub with jc and jz, outputs 02 then fd
P 0 45
P 1 2e
P 2 7a
P 3 e0
P 4 66
P 5 f0
P 6 2f
P 7 7a
P 8 e0
P 9 f0
P a 2e
P b e0
P c 65
P d f0
P e 03
P f 02
R
E 02
E fd
H
# run 2: lda add out, sta and reload, byte c kept from run 1
P 0 0e
P 1 1f
P 2 e0
P 3 3d
P 4 43
P 5 0d
P 6 e0
P 7 0c
P 8 e0
P 9 f0
P e c8
P f 64
R
E 2c
E 2c
E 65
H
Q

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    // cycle budget for one program run
    localparam int RUN_CYCLES = 5 * 64;
    localparam int HALT_WAIT  = RUN_CYCLES - 12;

    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;
    logic       clk;
    logic       ena;
    logic       rst_n;
    int         mismatch_count;
    int         other_count;

    // parsed golden records with a kind letter and two fields
    logic [7:0] rec_kind [$];
    logic [7:0] rec_a [$];
    logic [7:0] rec_b [$];
    int         run_count;
    int         prog_count;
    int         file_errors;
    int         cycle_count;
    int         cycle_limit;
    logic       limit_ready;

    tt_um_ece298a_8_bit_cpu_top uut (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .clk     (clk),
        .ena     (ena),
        .rst_n   (rst_n)
    );

    cpu_checker chk (
        .clk            (clk),
        .uo_out         (uo_out),
        .uio_out        (uio_out),
        .uio_oe         (uio_oe),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // whitespace separated tokens where # starts a comment line
    task automatic load_golden();
        int             fd;
        int             n;
        logic [63:0]    tok;
        logic [799:0]   rest;
        logic [7:0]     a;
        logic [7:0]     d;
        bit             done;
        fd = $fopen("bench/cpu_golden.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("cannot open bench/cpu_golden.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    file_errors++;
                    $display("golden file ends without a Q record");
                    done = 1'b1;
                end else if (tok == "#") begin
                    n = $fgets(rest, fd);
                end else if (tok == "P" || tok == "E") begin
                    d = '0;
                    if (tok == "P") begin
                        n = $fscanf(fd, "%h %h", a, d);
                        prog_count++;
                    end else begin
                        n = $fscanf(fd, "%h", a);
                    end
                    rec_kind.push_back(tok[7:0]);
                    rec_a.push_back(a);
                    rec_b.push_back(d);
                end else if (tok == "R" || tok == "H") begin
                    if (tok == "R") begin
                        run_count++;
                    end
                    rec_kind.push_back(tok[7:0]);
                    rec_a.push_back(8'h00);
                    rec_b.push_back(8'h00);
                end else if (tok == "Q") begin
                    done = 1'b1;
                end else begin
                    file_errors++;
                    $display("unknown record in the golden file");
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    // program mode stays on while the write strobe lasts one cycle
    task automatic program_byte(input addr_t addr, input data_t data);
        @(posedge clk);
        #2;
        ui_in                 = data;
        uio_in                = '0;
        uio_in[PROG_MODE_BIT] = 1'b1;
        uio_in[PROG_WE_BIT]   = 1'b1;
        uio_in[3:0]           = addr;
        @(posedge clk);
        #2;
        uio_in[PROG_WE_BIT] = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #2;
        uio_in = '0;
        chk.start_run();
    endtask

    // wait for halt and then watch a little longer for stray pulses
    task automatic await_halt();
        int waited;
        waited = 0;
        while (uio_out[HALT_BIT] !== 1'b1 && waited < HALT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        repeat (8) @(posedge clk);
        chk.finish_run();
    endtask

    initial begin
        ui_in                 = '0;
        uio_in                = '0;
        uio_in[PROG_MODE_BIT] = 1'b1;
        ena                   = 1'b1;
        rst_n                 = 1'b0;
        run_count             = 0;
        prog_count            = 0;
        file_errors           = 0;
        limit_ready           = 1'b0;
        load_golden();
        // each write costs two cycles
        cycle_limit = RUN_CYCLES * run_count + 2 * prog_count + 20;
        limit_ready = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "P": program_byte(rec_a[i][3:0], rec_b[i]);
                "R": start_run();
                "E": chk.push_expected(rec_a[i]);
                "H": await_halt();
            endcase
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 mismatch_count, other_count + file_errors);
        if (mismatch_count + other_count + file_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // hard stop in case a run never finishes
    initial begin
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test did not finish", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_pkg::*; (
    input  logic       clk,
    input  logic [7:0] uo_out,
    input  logic [7:0] uio_out,
    input  logic [7:0] uio_oe,
    output int         mismatch_count,
    output int         other_count
);

    // only the halt and out valid pins drive
    localparam logic [7:0] OE_EXPECTED = 8'h60;

    data_t expected_q [$];
    data_t exp_value;
    logic  armed;
    logic  seen_halt;

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        armed          = 1'b0;
        seen_halt      = 1'b0;
    end

    // expected OUT values arrive in file order
    task push_expected(input data_t value);
        expected_q.push_back(value);
    endtask

    task start_run();
        expected_q.delete();
        seen_halt = 1'b0;
        armed     = 1'b1;
    endtask

    // at end of run everything expected must have shown up
    task finish_run();
        if (!seen_halt) begin
            other_count++;
            $display("run did not end in the halted state");
        end
        if (expected_q.size() != 0) begin
            other_count++;
            $display("%0d expected outputs never arrived", expected_q.size());
        end
        armed = 1'b0;
    endtask

    // sample on the falling edge where outputs have settled
    always @(negedge clk) begin
        if (armed) begin
            if (uio_oe !== OE_EXPECTED) begin
                mismatch_count++;
                $display("error uio_oe expected %h got %h", OE_EXPECTED, uio_oe);
            end
            if (uio_out[OUT_VALID_BIT] === 1'b1) begin
                if (seen_halt) begin
                    other_count++;
                    $display("out_valid pulsed after the cpu halted");
                end else if (expected_q.size() == 0) begin
                    other_count++;
                    $display("output %h arrived with no value expected", uo_out);
                end else begin
                    exp_value = expected_q.pop_front();
                    if (uo_out !== exp_value) begin
                        mismatch_count++;
                        $display("error uo_out expected %h got %h", exp_value, uo_out);
                    end
                end
            end
            // halt is sticky until program mode comes back
            if (uio_out[HALT_BIT] === 1'b1) begin
                seen_halt = 1'b1;
            end else if (seen_halt) begin
                other_count++;
                $display("halt output dropped while the cpu should stay halted");
                armed = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tt_um_ece298a_8_bit_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tt_um_ece298a_8_bit_cpu_top import cpu_pkg::*; (
    input  logic [7:0] ui_in,
    input  logic [7:0] uio_in,
    output logic [7:0] uo_out,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       clk,
    // ena is always high on the tile, not looked at
    input  logic       ena,
    input  logic       rst_n
);

    ctrl_t   ctrl;
    opcode_t opcode;
    addr_t   pc;
    addr_t   jump_target;
    data_t   out_value;
    logic    carry;
    logic    zero;
    logic    halted;
    logic    out_valid;
    logic    cpu_hold;
    logic    prog_we;

    // program mode freezes the cpu, write strobe only counts in that mode
    assign cpu_hold = uio_in[PROG_MODE_BIT];
    assign prog_we  = uio_in[PROG_WE_BIT] & cpu_hold;

    control_block cb (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_hold (cpu_hold),
        .opcode   (opcode),
        .carry    (carry),
        .zero     (zero),
        .ctrl     (ctrl),
        .halted   (halted)
    );

    program_counter pc_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_hold   (cpu_hold),
        .inc        (ctrl.pc_inc),
        .load       (ctrl.pc_load),
        .load_value (jump_target),
        .pc         (pc)
    );

    datapath dp (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_hold    (cpu_hold),
        .ctrl        (ctrl),
        .pc          (pc),
        .prog_addr   (uio_in[ADDR_WIDTH-1:0]),
        .prog_data   (ui_in),
        .prog_we     (prog_we),
        .opcode      (opcode),
        .jump_target (jump_target),
        .carry       (carry),
        .zero        (zero),
        .out_value   (out_value),
        .out_valid   (out_valid)
    );

    assign uo_out = out_value;

    // status pins, the rest of uio stays input
    always_comb begin
        uio_out                = '0;
        uio_out[HALT_BIT]      = halted;
        uio_out[OUT_VALID_BIT] = out_valid;
    end

    assign uio_oe = (8'h01 << HALT_BIT) | (8'h01 << OUT_VALID_BIT);

endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cpu_hold,
    input  ctrl_t   ctrl,
    input  addr_t   pc,
    input  addr_t   prog_addr,
    input  data_t   prog_data,
    input  logic    prog_we,
    output opcode_t opcode,
    output addr_t   jump_target,
    output logic    carry,
    output logic    zero,
    output data_t   out_value,
    output logic    out_valid
);

    data_t bus;
    data_t reg_a;
    data_t reg_b;
    data_t reg_ir;
    addr_t reg_mar;
    data_t reg_out;
    data_t ram_rdata;
    data_t alu_result;
    logic  cpu_clear;

    assign cpu_clear = !rst_n || cpu_hold;

    // bus is a mux, idle value is zero
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:         bus = {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, pc};
            BUS_RAM:        bus = ram_rdata;
            // operand nibble, zero extended
            BUS_IR_OPERAND: bus = {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, reg_ir[ADDR_WIDTH-1:0]};
            BUS_A:          bus = reg_a;
            BUS_ALU:        bus = alu_result;
            default:        bus = '0;
        endcase
    end

    // register file, each loads from the bus on its own strobe
    always_ff @(posedge clk) begin
        if (cpu_clear) begin
            reg_a   <= '0;
            reg_b   <= '0;
            reg_ir  <= '0;
            reg_mar <= '0;
            reg_out <= '0;
        end else begin
            if (ctrl.a_load) begin
                reg_a <= bus;
            end
            if (ctrl.b_load) begin
                reg_b <= bus;
            end
            if (ctrl.ir_load) begin
                reg_ir <= bus;
            end
            // only the low nibble addresses ram
            if (ctrl.mar_load) begin
                reg_mar <= bus[ADDR_WIDTH-1:0];
            end
            if (ctrl.out_load) begin
                reg_out <= bus;
            end
        end
    end

    // strobe lands with the new output value
    always_ff @(posedge clk) begin
        if (cpu_clear) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load;
        end
    end

    dff_mem ram (
        .clk       (clk),
        .addr      (reg_mar),
        .wdata     (bus),
        .we        (ctrl.ram_write),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .rdata     (ram_rdata)
    );

    alu alu_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_hold   (cpu_hold),
        .a          (reg_a),
        .b          (reg_b),
        .sub        (ctrl.sub),
        .flags_load (ctrl.flags_load),
        .result     (alu_result),
        .carry      (carry),
        .zero       (zero)
    );

    // decode fields for the control block and pc
    assign opcode      = opcode_t'(reg_ir[DATA_WIDTH-1:ADDR_WIDTH]);
    assign jump_target = bus[ADDR_WIDTH-1:0];
    assign out_value   = reg_out;

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_hold,
    input  data_t a,
    input  data_t b,
    input  logic  sub,
    input  logic  flags_load,
    output data_t result,
    output logic  carry,
    output logic  zero
);

    logic [DATA_WIDTH:0] sum;
    data_t               b_op;

    // two's complement subtract, invert b and carry in one
    assign b_op   = sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_op} + {{DATA_WIDTH{1'b0}}, sub};
    assign result = sum[DATA_WIDTH-1:0];

    // flags only move on an add/sub writeback
    always_ff @(posedge clk) begin
        if (!rst_n || cpu_hold) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_load) begin
            // for sub this means a >= b
            carry <= sum[DATA_WIDTH];
            zero  <= (result == '0);
        end
    end

endmodule

`default_nettype wire

// ==== design/dff_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dff_mem import cpu_pkg::*; (
    input  logic  clk,
    input  addr_t addr,
    input  data_t wdata,
    input  logic  we,
    input  addr_t prog_addr,
    input  data_t prog_data,
    input  logic  prog_we,
    output data_t rdata
);

    // byte array, kept across cpu resets
    data_t mem [RAM_DEPTH];

    // loader port first, the cpu is frozen while it writes
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // async read at mar
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== design/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_hold,
    input  logic  inc,
    input  logic  load,
    input  addr_t load_value,
    output addr_t pc
);

    // jump wins over increment
    // natural wrap from 15 back to 0
    always_ff @(posedge clk) begin
        if (!rst_n || cpu_hold) begin
            pc <= '0;
        end else if (load) begin
            pc <= load_value;
        end else if (inc) begin
            pc <= pc + addr_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/control_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_block import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cpu_hold,
    input  opcode_t opcode,
    input  logic    carry,
    input  logic    zero,
    output ctrl_t   ctrl,
    output logic    halted
);

    tstate_t state;
    tstate_t state_next;

    // program mode holds the sequencer at T0 like a reset
    always_ff @(posedge clk) begin
        if (!rst_n || cpu_hold) begin
            state <= T0;
        end else begin
            state <= state_next;
        end
    end

    // five-step ring, HLT leaves it for good
    always_comb begin
        case (state)
            T0:      state_next = T1;
            T1:      state_next = T2;
            T2:      state_next = ctrl.halt ? HALTED : T3;
            T3:      state_next = T4;
            T4:      state_next = T0;
            default: state_next = HALTED;
        endcase
    end

    // decoder, everything idle unless a step below asks for it
    always_comb begin
        ctrl = '0;
        ctrl.bus_src = BUS_NONE;
        case (state)
            // fetch address
            T0: begin
                ctrl.bus_src  = BUS_PC;
                ctrl.mar_load = 1'b1;
            end
            // fetch instruction, advance pc
            T1: begin
                ctrl.bus_src = BUS_RAM;
                ctrl.ir_load = 1'b1;
                ctrl.pc_inc  = 1'b1;
            end
            T2: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        ctrl.bus_src  = BUS_IR_OPERAND;
                        ctrl.mar_load = 1'b1;
                    end
                    OP_LDI: begin
                        ctrl.bus_src = BUS_IR_OPERAND;
                        ctrl.a_load  = 1'b1;
                    end
                    OP_JMP: begin
                        ctrl.bus_src = BUS_IR_OPERAND;
                        ctrl.pc_load = 1'b1;
                    end
                    // conditional jumps look at the stored flags
                    OP_JC: begin
                        ctrl.bus_src = BUS_IR_OPERAND;
                        ctrl.pc_load = carry;
                    end
                    OP_JZ: begin
                        ctrl.bus_src = BUS_IR_OPERAND;
                        ctrl.pc_load = zero;
                    end
                    OP_OUT: begin
                        ctrl.bus_src  = BUS_A;
                        ctrl.out_load = 1'b1;
                    end
                    OP_HLT:  ctrl.halt = 1'b1;
                    default: ctrl.halt = 1'b0;
                endcase
            end
            T3: begin
                case (opcode)
                    OP_LDA: begin
                        ctrl.bus_src = BUS_RAM;
                        ctrl.a_load  = 1'b1;
                    end
                    // operand into b for the alu step
                    OP_ADD, OP_SUB: begin
                        ctrl.bus_src = BUS_RAM;
                        ctrl.b_load  = 1'b1;
                    end
                    OP_STA: begin
                        ctrl.bus_src   = BUS_A;
                        ctrl.ram_write = 1'b1;
                    end
                    default: ctrl.bus_src = BUS_NONE;
                endcase
            end
            T4: begin
                // write back alu result and latch flags
                if (opcode == OP_ADD || opcode == OP_SUB) begin
                    ctrl.bus_src    = BUS_ALU;
                    ctrl.a_load     = 1'b1;
                    ctrl.flags_load = 1'b1;
                    ctrl.sub        = (opcode == OP_SUB);
                end
            end
            default: ctrl.bus_src = BUS_NONE;
        endcase
    end

    assign halted = (state == HALTED);

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // datapath and address widths
    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 4;
    localparam int RAM_DEPTH  = 16;

    // uio pin positions shared by top level and bench
    localparam int PROG_WE_BIT   = 4;
    localparam int HALT_BIT      = 5;
    localparam int OUT_VALID_BIT = 6;
    localparam int PROG_MODE_BIT = 7;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // high nibble of the instruction byte, unlisted codes decode as nop
    typedef enum logic [3:0] {
        OP_LDA = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_STA = 4'd3,
        OP_LDI = 4'd4,
        OP_JMP = 4'd5,
        OP_JC  = 4'd6,
        OP_JZ  = 4'd7,
        OP_OUT = 4'd14,
        OP_HLT = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        T0     = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T4     = 3'd4,
        HALTED = 3'd5
    } tstate_t;

    // who drives the shared bus this cycle
    typedef enum logic [2:0] {
        BUS_NONE       = 3'd0,
        BUS_PC         = 3'd1,
        BUS_RAM        = 3'd2,
        BUS_IR_OPERAND = 3'd3,
        BUS_A          = 3'd4,
        BUS_ALU        = 3'd5
    } bus_src_t;

    // control word, one per clock
    typedef struct packed {
        bus_src_t bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     sub;
        logic     flags_load;
        logic     out_load;
        logic     halt;
    } ctrl_t;

endpackage

`default_nettype wire
